// ==== alu.sv ====
`timescale 1ns/100ps

module alu (
  input  procPkg::dataT      regA,
  input  procPkg::dataT      regB,
  input  procPkg::instrWordT romData,
  output procPkg::dataT      aluResult
);
  import procPkg::*;

  // Purely combinational
  // The operation comes from the upper nibble of the byte now on the ROM output
  always_comb begin
    case (romData.instr.aluOp)
      // Arithmetic, all results wrap modulo 256
      aluAdd: aluResult = regA + regB;
      aluSub: aluResult = regA - regB;
      // Only the low byte of the product is kept
      aluMul: aluResult = regA * regB;

      // Shifts by one place, zero filled
      aluShl: aluResult = regA << 1;
      aluShr: aluResult = regA >> 1;

      // Increment and decrement
      aluIncA: aluResult = regA + dataT'(1);
      aluIncB: aluResult = regB + dataT'(1);
      aluDecA: aluResult = regA - dataT'(1);
      aluDecB: aluResult = regB - dataT'(1);

      // Comparisons give 1 or 0, used by the branch test
      aluEq: aluResult = dataT'(regA == regB);
      aluGt: aluResult = dataT'(regA > regB);
      aluLt: aluResult = dataT'(regA < regB);

      // Unused codes
      default: aluResult = '0;
    endcase
  end

endmodule

// ==== controlFsm.sv ====
`timescale 1ns/100ps

module controlFsm (
  input  logic               CLK,
  input  logic               RESET,
  input  procPkg::instrWordT romData,
  input  procPkg::dataT      aluResult,
  input  procPkg::irqT       irqRaise,
  output procPkg::irqT       irqAck,
  output logic               pcLoadVector,
  output logic               pcVectorSel,
  output logic               pcLoadRom,
  output logic               pcAdvance,
  output logic               pcAdvanceTwo,
  output logic               pcFetchOperand,
  output logic               pcSaveContext,
  output logic               pcReturn,
  output logic               loadRegFromBus,
  output logic               loadRegFromAlu,
  output logic               regSelect,
  output logic               presentAddr,
  output logic               startWrite
);
  import procPkg::*;

  // One short pipeline of states per instruction
  typedef enum logic [4:0] {
    stIdle,
    stThread0,
    stThread1,
    stThread2,
    stDispatch,
    stRead0,
    stRead1,
    stRead2,
    stRead3,
    stWrite0,
    stWrite1,
    stMaths,
    stBranchTest,
    stBranchLoad,
    stGoto0,
    stGoto1,
    stIdle0,
    stIdle1,
    stCall0,
    stCall1,
    stReturn,
    stSettle
  } stateT;

  stateT state;
  stateT nextState;
  // Acknowledge for the line served, registered into irqAck
  irqT ackNext;

  // Starts at dispatch, ROM address 0 is fetched during reset
  always_ff @(posedge CLK) begin
    if (RESET) begin
      state  <= stDispatch;
      irqAck <= '0;
    end else begin
      state  <= nextState;
      irqAck <= ackNext;
    end
  end

  always_comb begin
    // Strobes are single cycle pulses by default
    nextState      = state;
    ackNext        = '0;
    pcLoadVector   = 1'b0;
    pcVectorSel    = 1'b0;
    pcLoadRom      = 1'b0;
    pcAdvance      = 1'b0;
    pcAdvanceTwo   = 1'b0;
    pcFetchOperand = 1'b0;
    pcSaveContext  = 1'b0;
    pcReturn       = 1'b0;
    loadRegFromBus = 1'b0;
    loadRegFromAlu = 1'b0;
    regSelect      = 1'b0;
    presentAddr    = 1'b0;
    startWrite     = 1'b0;

    case (state)
      //////////////////////////////
      // Thread start
      //////////////////////////////
      stIdle: begin
        // Line 0 wins when both are raised
        if (irqRaise[0]) begin
          pcLoadVector = 1'b1;
          ackNext      = 2'b01;
          nextState    = stThread0;
        end else if (irqRaise[1]) begin
          pcLoadVector = 1'b1;
          pcVectorSel  = 1'b1;
          ackNext      = 2'b10;
          nextState    = stThread0;
        end
      end
      // Vector address on the ROM, data arrives next cycle
      stThread0: nextState = stThread1;
      stThread1: begin
        pcLoadRom = 1'b1;
        nextState = stThread2;
      end
      // Wait for the first instruction byte
      stThread2: nextState = stDispatch;

      //////////////////////////////
      // Dispatch
      //////////////////////////////
      stDispatch: begin
        case (romData.instr.opcode)
          opReadA, opReadB: begin
            regSelect      = 1'b1;
            pcFetchOperand = 1'b1;
            nextState      = stRead0;
          end
          opWriteA, opWriteB: begin
            regSelect      = 1'b1;
            pcFetchOperand = 1'b1;
            nextState      = stWrite0;
          end
          // No operand byte, the ALU reads the instruction itself
          opMathA, opMathB: begin
            regSelect = 1'b1;
            nextState = stMaths;
          end
          opBranch: begin
            pcFetchOperand = 1'b1;
            nextState      = stBranchTest;
          end
          opGoto: begin
            pcFetchOperand = 1'b1;
            nextState      = stGoto0;
          end
          opCall: begin
            pcFetchOperand = 1'b1;
            nextState      = stCall0;
          end
          opReturn: nextState = stReturn;
          opIdle:   nextState = stIdle0;
          // Unused codes step over one byte
          default: begin
            pcAdvance = 1'b1;
            nextState = stSettle;
          end
        endcase
      end

      //////////////////////////////
      // Memory read
      //////////////////////////////
      // Operand address still on its way from the ROM
      stRead0: nextState = stRead1;
      stRead1: begin
        presentAddr  = 1'b1;
        pcAdvance    = 1'b1;
        pcAdvanceTwo = 1'b1;
        nextState    = stRead2;
      end
      // Memory registers the data at the end of this cycle
      stRead2: nextState = stRead3;
      stRead3: begin
        loadRegFromBus = 1'b1;
        nextState      = stDispatch;
      end

      //////////////////////////////
      // Memory write
      //////////////////////////////
      stWrite0: begin
        pcAdvance    = 1'b1;
        pcAdvanceTwo = 1'b1;
        nextState    = stWrite1;
      end
      // Write address on the ROM output now
      stWrite1: begin
        startWrite = 1'b1;
        nextState  = stDispatch;
      end

      //////////////////////////////
      // Maths and flow control
      //////////////////////////////
      stMaths: begin
        loadRegFromAlu = 1'b1;
        pcAdvance      = 1'b1;
        nextState      = stSettle;
      end
      // Comparison result is valid while the instruction is on the ROM
      stBranchTest: begin
        if (aluResult == '0) begin
          pcAdvance    = 1'b1;
          pcAdvanceTwo = 1'b1;
          nextState    = stSettle;
        end else begin
          nextState = stBranchLoad;
        end
      end
      stBranchLoad: begin
        pcLoadRom = 1'b1;
        nextState = stSettle;
      end
      stGoto0: nextState = stGoto1;
      stGoto1: begin
        pcLoadRom = 1'b1;
        nextState = stSettle;
      end
      stCall0: begin
        pcSaveContext = 1'b1;
        nextState     = stCall1;
      end
      stCall1: begin
        pcLoadRom = 1'b1;
        nextState = stSettle;
      end
      stReturn: begin
        pcReturn  = 1'b1;
        nextState = stSettle;
      end

      // Two drain cycles, then wait for an interrupt
      stIdle0: nextState = stIdle1;
      stIdle1: nextState = stIdle;

      // New PC on the ROM address, byte shows next cycle
      stSettle: nextState = stDispatch;

      default: nextState = stDispatch;
    endcase
  end

endmodule

// ==== dataPath.sv ====
`timescale 1ns/100ps

module dataPath (
  input  logic               CLK,
  input  logic               RESET,
  input  procPkg::dataT      busDataIn,
  input  procPkg::instrWordT romData,
  input  procPkg::dataT      aluResult,
  input  logic               loadRegFromBus,
  input  logic               loadRegFromAlu,
  input  logic               regSelect,
  input  logic               presentAddr,
  input  logic               startWrite,
  output procPkg::dataT      regA,
  output procPkg::dataT      regB,
  output procPkg::dataT      busAddr,
  output procPkg::dataT      busDataOut,
  output logic               busWe
);
  import procPkg::*;

  // Target register of the running instruction, high for B
  logic selB;
  // Opcode bits of the instruction byte
  logic [3:0] opcodeBits;
  // Value and enable for the register file
  dataT loadValue;
  logic loadEnable;

  assign opcodeBits = romData.instr.opcode;

  //////////////////////////////
  // Register select
  //////////////////////////////

  // Opcode bit 0 picks B for read, write and maths
  // Captured at dispatch while the instruction is on the ROM output
  always_ff @(posedge CLK) begin
    if (RESET) begin
      selB <= 1'b0;
    end else if (regSelect) begin
      selB <= opcodeBits[0];
    end
  end

  //////////////////////////////
  // Registers A and B
  //////////////////////////////

  assign loadValue  = loadRegFromBus ? busDataIn : aluResult;
  assign loadEnable = loadRegFromBus | loadRegFromAlu;

  always_ff @(posedge CLK) begin
    if (loadEnable && !selB) begin
      regA <= loadValue;
    end
    if (loadEnable && selB) begin
      regB <= loadValue;
    end
  end

  //////////////////////////////
  // Bus outputs
  //////////////////////////////

  // Address lives for one cycle, then parks again
  // Write strobe is a single cycle pulse
  always_ff @(posedge CLK) begin
    if (RESET) begin
      busAddr <= idleBusAddr;
      busWe   <= 1'b0;
    end else begin
      busWe <= startWrite;
      if (presentAddr || startWrite) begin
        busAddr <= romData.operand;
      end else begin
        busAddr <= idleBusAddr;
      end
    end
  end

  // Write data launched together with the address
  always_ff @(posedge CLK) begin
    if (startWrite) begin
      busDataOut <= selB ? regB : regA;
    end
  end

endmodule

// ==== procPkg.sv ====
package procPkg;

  // One byte is both the data word and the address word
  localparam int dataW = 8;

  typedef logic [dataW-1:0] dataT;

  // One request or acknowledge bit per interrupt line
  typedef logic [1:0] irqT;

  //////////////////////////////
  // Instruction lower nibble
  //////////////////////////////

  // Codes 7, 8 and 13 to 15 are left unnamed and run as no-ops
  typedef enum logic [3:0] {
    opReadA  = 4'd0,
    opReadB  = 4'd1,
    opWriteA = 4'd2,
    opWriteB = 4'd3,
    opMathA  = 4'd4,
    opMathB  = 4'd5,
    opBranch = 4'd6,
    opGoto   = 4'd9,
    opIdle   = 4'd10,
    opCall   = 4'd11,
    opReturn = 4'd12
  } opcodeT;

  //////////////////////////////
  // Instruction upper nibble
  //////////////////////////////

  // Codes 12 to 15 give a zero result
  typedef enum logic [3:0] {
    aluAdd  = 4'd0,
    aluSub  = 4'd1,
    aluMul  = 4'd2,
    aluShl  = 4'd3,
    aluShr  = 4'd4,
    aluIncA = 4'd5,
    aluIncB = 4'd6,
    aluDecA = 4'd7,
    aluDecB = 4'd8,
    aluEq   = 4'd9,
    aluGt   = 4'd10,
    aluLt   = 4'd11
  } aluOpT;

  // A ROM byte seen as an instruction or as an operand byte
  typedef union packed {
    struct packed {
      aluOpT  aluOp;
      opcodeT opcode;
    } instr;
    dataT operand;
  } instrWordT;

  // Bus address parked here between accesses
  localparam dataT idleBusAddr = 8'hFF;

  // ROM bytes holding the thread start addresses
  localparam dataT irqVector0 = 8'hFF;
  localparam dataT irqVector1 = 8'hFE;

endpackage

// ==== processorTop.sv ====
`timescale 1ns/100ps

module processorTop (
  input  logic          CLK,
  input  logic          RESET,
  input  procPkg::dataT romData,
  input  procPkg::dataT busDataIn,
  input  procPkg::irqT  irqRaise,
  output procPkg::dataT romAddr,
  output procPkg::dataT busAddr,
  output procPkg::dataT busDataOut,
  output logic          busWe,
  output procPkg::irqT  irqAck
);
  import procPkg::*;

  // Registers to the ALU
  dataT regA;
  dataT regB;
  // ALU result to registers and branch test
  dataT aluResult;

  // PC commands
  logic pcLoadVector;
  logic pcVectorSel;
  logic pcLoadRom;
  logic pcAdvance;
  logic pcAdvanceTwo;
  logic pcFetchOperand;
  logic pcSaveContext;
  logic pcReturn;

  // Register and bus commands
  logic loadRegFromBus;
  logic loadRegFromAlu;
  logic regSelect;
  logic presentAddr;
  logic startWrite;

  controlFsm u_controlFsm (
    .CLK            (CLK),
    .RESET          (RESET),
    .romData        (romData),
    .aluResult      (aluResult),
    .irqRaise       (irqRaise),
    .irqAck         (irqAck),
    .pcLoadVector   (pcLoadVector),
    .pcVectorSel    (pcVectorSel),
    .pcLoadRom      (pcLoadRom),
    .pcAdvance      (pcAdvance),
    .pcAdvanceTwo   (pcAdvanceTwo),
    .pcFetchOperand (pcFetchOperand),
    .pcSaveContext  (pcSaveContext),
    .pcReturn       (pcReturn),
    .loadRegFromBus (loadRegFromBus),
    .loadRegFromAlu (loadRegFromAlu),
    .regSelect      (regSelect),
    .presentAddr    (presentAddr),
    .startWrite     (startWrite)
  );

  programCounter u_programCounter (
    .CLK            (CLK),
    .RESET          (RESET),
    .pcLoadVector   (pcLoadVector),
    .pcVectorSel    (pcVectorSel),
    .pcLoadRom      (pcLoadRom),
    .pcAdvance      (pcAdvance),
    .pcAdvanceTwo   (pcAdvanceTwo),
    .pcFetchOperand (pcFetchOperand),
    .pcSaveContext  (pcSaveContext),
    .pcReturn       (pcReturn),
    .romData        (romData),
    .romAddr        (romAddr)
  );

  dataPath u_dataPath (
    .CLK            (CLK),
    .RESET          (RESET),
    .busDataIn      (busDataIn),
    .romData        (romData),
    .aluResult      (aluResult),
    .loadRegFromBus (loadRegFromBus),
    .loadRegFromAlu (loadRegFromAlu),
    .regSelect      (regSelect),
    .presentAddr    (presentAddr),
    .startWrite     (startWrite),
    .regA           (regA),
    .regB           (regB),
    .busAddr        (busAddr),
    .busDataOut     (busDataOut),
    .busWe          (busWe)
  );

  alu u_alu (
    .regA      (regA),
    .regB      (regB),
    .romData   (romData),
    .aluResult (aluResult)
  );

endmodule

// ==== programCounter.sv ====
`timescale 1ns/100ps

module programCounter (
  input  logic               CLK,
  input  logic               RESET,
  input  logic               pcLoadVector,
  input  logic               pcVectorSel,
  input  logic               pcLoadRom,
  input  logic               pcAdvance,
  input  logic               pcAdvanceTwo,
  input  logic               pcFetchOperand,
  input  logic               pcSaveContext,
  input  logic               pcReturn,
  input  procPkg::instrWordT romData,
  output procPkg::dataT      romAddr
);
  import procPkg::*;

  // Current instruction address
  dataT pc;
  // Points one byte past the instruction, for the operand fetch
  logic fetchOffset;
  // Return address of the single call level
  dataT savedContext;
  // Advance amount, one or two bytes
  dataT advanceStep;

  assign advanceStep = pcAdvanceTwo ? dataT'(2) : dataT'(1);

  //////////////////////////////
  // PC update
  //////////////////////////////

  // Strobes come from one FSM state at a time
  always_ff @(posedge CLK) begin
    if (RESET) begin
      pc <= '0;
    end else if (pcLoadVector) begin
      // Line 1 uses the byte just below the line 0 vector
      pc <= pcVectorSel ? irqVector1 : irqVector0;
    end else if (pcLoadRom) begin
      // Jump target or thread start read from ROM
      pc <= romData.operand;
    end else if (pcReturn) begin
      pc <= savedContext;
    end else if (pcAdvance) begin
      pc <= pc + advanceStep;
    end
  end

  // Offset lasts exactly one cycle after the request
  always_ff @(posedge CLK) begin
    if (RESET) begin
      fetchOffset <= 1'b0;
    end else begin
      fetchOffset <= pcFetchOperand;
    end
  end

  // Call returns past its own two bytes
  always_ff @(posedge CLK) begin
    if (pcSaveContext) begin
      savedContext <= pc + dataT'(2);
    end
  end

  // ROM address, registered ROM answers one cycle later
  assign romAddr = pc + dataT'(fetchOffset);

endmodule

// ==== runSim.sh ====
#!/bin/sh
# Compile and run the processor testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f verilog.f --top-module tbProcessor -o simProcessor
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/simProcessor > sim.log 2>&1
status=$?
cat sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
  echo "Testbench reported failure"
  exit 1
fi
if [ $status -ne 0 ]; then
  echo "Simulator exited with status $status"
  exit 1
fi
exit 0

// ==== tbProcessor.sv ====
`timescale 1ns/100ps

module tbProcessor;
  import procPkg::*;

  // Run length budget, one entry per directed run
  localparam int testRuns  = 22;
  localparam int waitLimit = 200;

  // Every thread ends by copying doneValue to doneAddr
  localparam dataT doneSrc   = 8'h2F;
  localparam dataT doneAddr  = 8'hF0;
  localparam dataT doneValue = 8'hD0;

  logic CLK = 1'b0;
  logic RESET;
  dataT romData = '0;
  dataT busDataIn = '0;
  irqT  irqRaise;
  dataT romAddr;
  dataT busAddr;
  dataT busDataOut;
  logic busWe;
  irqT  irqAck;

  // Memory models and their registered read outputs
  dataT rom [0:255];
  dataT ram [0:255];
  dataT romOut = '0;
  dataT ramOut = '0;

  // Observed and expected bus writes and acknowledges
  dataT seenAddr [$];
  dataT seenData [$];
  dataT expAddr [$];
  dataT expData [$];
  irqT  seenAck [$];
  irqT  expAck [$];
  int   doneSeen;

  string       testName;
  dataT        emitAddr;
  logic [31:0] rngState;

  processorTop u_dut (
    .CLK        (CLK),
    .RESET      (RESET),
    .romData    (romData),
    .busDataIn  (busDataIn),
    .irqRaise   (irqRaise),
    .romAddr    (romAddr),
    .busAddr    (busAddr),
    .busDataOut (busDataOut),
    .busWe      (busWe),
    .irqAck     (irqAck)
  );

  // 8 ns clock
  always #4 CLK = ~CLK;

  //////////////////////////////
  // Memory models and monitor
  //////////////////////////////

  // Both memories capture the address at the rising edge
  // RAM is read first, then written
  always @(posedge CLK) begin
    romOut = rom[romAddr];
    ramOut = ram[busAddr];
    if (busWe) begin
      ram[busAddr] = busDataOut;
      seenAddr.push_back(busAddr);
      seenData.push_back(busDataOut);
      if (busAddr == doneAddr) begin
        doneSeen++;
      end
    end
    // Ack pulses last one cycle, so each entry is one pulse
    if (irqAck != 2'b00) begin
      seenAck.push_back(irqAck);
    end
  end

  // Read data reaches the DUT pins half a cycle later
  always @(negedge CLK) begin
    romData   = romOut;
    busDataIn = ramOut;
  end

  //////////////////////////////
  // Error handling and checks
  //////////////////////////////

  task automatic failRun(input string reason);
    $display("%s", reason);
    $display("Simulation finished: FAIL");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic checkByte(input string what, input dataT expected, input dataT actual);
    if (actual !== expected) begin
      failRun($sformatf("CHECK FAILED %s, %s: expected %h, actual %h",
                        testName, what, expected, actual));
    end
  endtask

  task automatic checkAck(input string what, input irqT expected, input irqT actual);
    if (actual !== expected) begin
      failRun($sformatf("CHECK FAILED %s, %s: expected %b, actual %b",
                        testName, what, expected, actual));
    end
  endtask

  task automatic checkFlag(input string what, input logic expected, input logic actual);
    if (actual !== expected) begin
      failRun($sformatf("CHECK FAILED %s, %s: expected %b, actual %b",
                        testName, what, expected, actual));
    end
  endtask

  task automatic checkCount(input string what, input int expected, input int actual);
    if (actual != expected) begin
      failRun($sformatf("CHECK FAILED %s, %s: expected %0d, actual %0d",
                        testName, what, expected, actual));
    end
  endtask

  // Order, address and data of every write
  task automatic compareWrites();
    checkCount("write count", expAddr.size(), seenAddr.size());
    foreach (expAddr[i]) begin
      checkByte($sformatf("write %0d address", i), expAddr[i], seenAddr[i]);
      checkByte($sformatf("write %0d data", i), expData[i], seenData[i]);
    end
  endtask

  task automatic compareAcks();
    checkCount("ack pulse count", expAck.size(), seenAck.size());
    foreach (expAck[i]) begin
      checkAck($sformatf("ack pulse %0d", i), expAck[i], seenAck[i]);
    end
  endtask

  //////////////////////////////
  // Stimulus helpers
  //////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic drawByte(output dataT value);
    rngState = xorshift32(rngState);
    value = rngState[7:0];
  endtask

  // Reference results straight from the operation table
  function automatic dataT aluModel(input logic [3:0] code, input dataT a, input dataT b);
    logic [15:0] wide;
    wide = 16'd0;
    case (code)
      aluAdd:  wide = {8'd0, a} + {8'd0, b};
      aluSub:  wide = {8'd0, a} - {8'd0, b};
      aluMul:  wide = {8'd0, a} * {8'd0, b};
      aluShl:  wide = {7'd0, a, 1'b0};
      aluShr:  wide = {9'd0, a[7:1]};
      aluIncA: wide = {8'd0, a} + 16'd1;
      aluIncB: wide = {8'd0, b} + 16'd1;
      aluDecA: wide = {8'd0, a} - 16'd1;
      aluDecB: wide = {8'd0, b} - 16'd1;
      aluEq:   wide = (a == b) ? 16'd1 : 16'd0;
      aluGt:   wide = (a > b) ? 16'd1 : 16'd0;
      aluLt:   wide = (a < b) ? 16'd1 : 16'd0;
      default: wide = 16'd0;
    endcase
    return wide[7:0];
  endfunction

  // Fresh memories and empty queues for each run
  task automatic startTest(input string name);
    dataT fillAddr;
    testName = name;
    seenAddr.delete();
    seenData.delete();
    expAddr.delete();
    expData.delete();
    seenAck.delete();
    expAck.delete();
    doneSeen = 0;
    for (int i = 0; i < 256; i++) begin
      fillAddr = dataT'(i);
      // Go-idle in every byte, upper nibble varies with the address
      rom[fillAddr] = {fillAddr[7:4] ^ fillAddr[3:0], opIdle};
      ram[fillAddr] = {fillAddr[2:0], fillAddr[7:3]} ^ 8'h96;
    end
    ram[doneSrc] = doneValue;
  endtask

  task automatic setOrigin(input dataT addr);
    emitAddr = addr;
  endtask

  task automatic putInstr(input logic [3:0] aluCode, input opcodeT op);
    instrWordT word;
    word.instr.aluOp  = aluOpT'(aluCode);
    word.instr.opcode = op;
    rom[emitAddr] = word.operand;
    emitAddr = emitAddr + 8'd1;
  endtask

  task automatic putOperand(input dataT value);
    rom[emitAddr] = value;
    emitAddr = emitAddr + 8'd1;
  endtask

  // Copy the done byte through B, then go idle
  task automatic putDoneTail();
    putInstr(4'd0, opReadB);
    putOperand(doneSrc);
    putInstr(4'd0, opWriteB);
    putOperand(doneAddr);
    putInstr(4'd0, opIdle);
  endtask

  task automatic expectWrite(input dataT addr, input dataT data);
    expAddr.push_back(addr);
    expData.push_back(data);
  endtask

  // Hold each line until its own ack arrives
  task automatic raiseIrq(input irqT lines);
    int waited;
    waited = 0;
    @(negedge CLK);
    irqRaise = lines;
    while (irqRaise != 2'b00 && waited < waitLimit) begin
      @(negedge CLK);
      irqRaise = irqRaise & ~irqAck;
      waited++;
    end
    if (irqRaise != 2'b00) begin
      failRun($sformatf("%s: interrupt %b was never acknowledged", testName, irqRaise));
    end
  endtask

  task automatic waitDone(input int count);
    int waited;
    waited = 0;
    while (doneSeen < count && waited < waitLimit) begin
      @(negedge CLK);
      waited++;
    end
    if (doneSeen < count) begin
      failRun($sformatf("%s: thread never reached its final write", testName));
    end
  endtask

  task automatic serveThreads(input irqT lines, input int threads);
    raiseIrq(lines);
    waitDone(threads);
    compareWrites();
    compareAcks();
  endtask

  //////////////////////////////
  // Directed tests
  //////////////////////////////

  task automatic testReset();
    startTest("reset");
    repeat (2) @(negedge CLK);
    RESET = 1'b0;
    // Core runs the go-idle at address 0 and must stay silent
    repeat (20) begin
      @(negedge CLK);
      checkFlag("busWe", 1'b0, busWe);
      checkAck("irqAck", 2'b00, irqAck);
      checkByte("busAddr", idleBusAddr, busAddr);
    end
  endtask

  task automatic testMemoryMoves();
    dataT a;
    dataT b;
    startTest("memory moves");
    drawByte(a);
    drawByte(b);
    ram[8'h20] = a;
    ram[8'h21] = b;
    setOrigin(8'h10);
    putInstr(4'd0, opReadA);
    putOperand(8'h20);
    putInstr(4'd0, opReadB);
    putOperand(8'h21);
    putInstr(4'd0, opWriteB);
    putOperand(8'h22);
    putInstr(4'd0, opWriteA);
    putOperand(8'h23);
    putDoneTail();
    rom[irqVector0] = 8'h10;
    expectWrite(8'h22, b);
    expectWrite(8'h23, a);
    expectWrite(doneAddr, doneValue);
    expAck.push_back(2'b01);
    serveThreads(2'b01, 1);
    checkByte("RAM 0x22", b, ram[8'h22]);
    checkByte("RAM 0x23", a, ram[8'h23]);
  endtask

  task automatic testAluOps();
    dataT a;
    dataT b;
    logic [3:0] code;
    // Codes 0 to 11, then one unused code
    for (int k = 0; k < 13; k++) begin
      code = (k == 12) ? 4'd15 : 4'(k);
      startTest($sformatf("ALU code %0d", code));
      drawByte(a);
      drawByte(b);
      ram[8'h20] = a;
      ram[8'h21] = b;
      setOrigin(8'h40);
      putInstr(4'd0, opReadA);
      putOperand(8'h20);
      putInstr(4'd0, opReadB);
      putOperand(8'h21);
      putInstr(code, opMathA);
      putInstr(4'd0, opWriteA);
      putOperand(8'h30);
      putDoneTail();
      rom[irqVector0] = 8'h40;
      expectWrite(8'h30, aluModel(code, a, b));
      expectWrite(doneAddr, doneValue);
      expAck.push_back(2'b01);
      serveThreads(2'b01, 1);
    end
  endtask

  task automatic runBranch(input logic [3:0] cmp, input dataT a, input dataT b);
    dataT marker;
    startTest($sformatf("branch code %0d a=%h b=%h", cmp, a, b));
    ram[8'h20] = a;
    ram[8'h21] = b;
    ram[8'h22] = 8'h11;
    ram[8'h23] = 8'h22;
    setOrigin(8'h40);
    putInstr(4'd0, opReadA);
    putOperand(8'h20);
    putInstr(4'd0, opReadB);
    putOperand(8'h21);
    putInstr(cmp, opBranch);
    putOperand(8'h4C);
    // Fall-through path
    putInstr(4'd0, opReadA);
    putOperand(8'h23);
    putInstr(4'd0, opWriteA);
    putOperand(8'h30);
    putInstr(4'd0, opGoto);
    putOperand(8'h50);
    // Taken path at 0x4C
    putInstr(4'd0, opReadA);
    putOperand(8'h22);
    putInstr(4'd0, opWriteA);
    putOperand(8'h30);
    // Goto jumps over a write to 0x31
    putInstr(4'd0, opGoto);
    putOperand(8'h54);
    putInstr(4'd0, opWriteA);
    putOperand(8'h31);
    putDoneTail();
    rom[irqVector0] = 8'h40;
    marker = (aluModel(cmp, a, b) != 8'd0) ? 8'h11 : 8'h22;
    expectWrite(8'h30, marker);
    expectWrite(doneAddr, doneValue);
    expAck.push_back(2'b01);
    serveThreads(2'b01, 1);
  endtask

  task automatic testBranches();
    dataT x;
    dataT lo;
    dataT hi;
    drawByte(x);
    lo = {1'b0, x[6:0]};
    hi = {1'b1, x[6:0]};
    // Each comparison once taken, once not
    runBranch(aluEq, lo, lo);
    runBranch(aluEq, hi, lo);
    runBranch(aluGt, hi, lo);
    runBranch(aluGt, lo, hi);
    runBranch(aluLt, lo, hi);
    runBranch(aluLt, hi, lo);
  endtask

  task automatic testCallPriority();
    startTest("call and priority");
    ram[8'h24] = 8'h33;
    ram[8'h25] = 8'h44;
    ram[8'h26] = 8'h55;
    // Line 0 thread
    setOrigin(8'h10);
    putInstr(4'd0, opReadA);
    putOperand(8'h26);
    putInstr(4'd0, opWriteA);
    putOperand(8'h34);
    putDoneTail();
    // Line 1 thread calls the subroutine first
    setOrigin(8'h60);
    putInstr(4'd0, opCall);
    putOperand(8'h80);
    putInstr(4'd0, opReadA);
    putOperand(8'h25);
    putInstr(4'd0, opWriteA);
    putOperand(8'h36);
    putDoneTail();
    // Subroutine
    setOrigin(8'h80);
    putInstr(4'd0, opReadA);
    putOperand(8'h24);
    putInstr(4'd0, opWriteA);
    putOperand(8'h35);
    putInstr(4'd0, opReturn);
    rom[irqVector0] = 8'h10;
    rom[irqVector1] = 8'h60;
    expectWrite(8'h34, 8'h55);
    expectWrite(doneAddr, doneValue);
    expectWrite(8'h35, 8'h33);
    expectWrite(8'h36, 8'h44);
    expectWrite(doneAddr, doneValue);
    expAck.push_back(2'b01);
    expAck.push_back(2'b10);
    serveThreads(2'b11, 2);
  endtask

  //////////////////////////////
  // Main sequence and watchdog
  //////////////////////////////

  initial begin
    RESET    = 1'b1;
    irqRaise = 2'b00;
    rngState = 32'hfa07_4082;
    testReset();
    testMemoryMoves();
    testAluOps();
    testBranches();
    testCallPriority();
    $display("Simulation finished: PASS");
    $finish;
  end

  // 200 cycles per run is far above the longest thread
  initial begin
    #(testRuns * 200 * 8);
    failRun("Watchdog expired, the DUT stopped making progress");
  end

endmodule

// ==== verilog.f ====
procPkg.sv
alu.sv
programCounter.sv
dataPath.sv
controlFsm.sv
processorTop.sv
tbProcessor.sv
